/* afu_pkg.sv */
// Memory test accelerator definitions
package afu_pkg;

    // ========================================
    // Bus and counter widths
    // ========================================

    // Line address width on the host read channel
    localparam int ADDR_W      = 42;
    // Width of one read response word and of every MMIO data word
    localparam int DATA_W      = 64;
    // MMIO byte address width
    localparam int MMIO_ADDR_W = 16;
    // MMIO transaction tag width
    localparam int TID_W       = 9;
    // Width of the line count and of the response counter
    localparam int CNT_W       = 16;

    // ========================================
    // Register map, byte offsets
    // ========================================

    localparam logic [MMIO_ADDR_W-1:0] CSR_DFH     = 16'h000;
    localparam logic [MMIO_ADDR_W-1:0] CSR_ID_L    = 16'h008;
    localparam logic [MMIO_ADDR_W-1:0] CSR_ID_H    = 16'h010;
    localparam logic [MMIO_ADDR_W-1:0] CSR_BASE    = 16'h020;
    localparam logic [MMIO_ADDR_W-1:0] CSR_COUNT   = 16'h028;
    localparam logic [MMIO_ADDR_W-1:0] CSR_CTRL    = 16'h030;
    localparam logic [MMIO_ADDR_W-1:0] CSR_STATUS  = 16'h038;
    localparam logic [MMIO_ADDR_W-1:0] CSR_SUM     = 16'h040;
    localparam logic [MMIO_ADDR_W-1:0] CSR_RSP_CNT = 16'h048;

    // ========================================
    // Feature header constants
    // ========================================

    // The next feature in the chain sits 4 KB above this one
    localparam logic [23:0] NEXT_DFH_OFFSET = 24'h001000;
    // Feature type code of an accelerator function
    localparam logic [3:0]  DFH_TYPE_AFU    = 4'h1;
    // Identifier of this accelerator, low and high halves
    localparam logic [63:0] AFU_ID_L        = 64'h9d73_a2c4_5b10_e8f6;
    localparam logic [63:0] AFU_ID_H        = 64'h4c1e_07b9_d35a_2f81;

    // One MMIO read word, seen either as plain data or as header fields
    typedef union packed {
        logic [63:0] raw;
        struct packed {
            logic [3:0]  feature_type;
            logic [18:0] rsvd_hi;
            logic        end_of_list;
            logic [15:0] rsvd_lo;
            logic [23:0] next_offset;
        } dfh;
    } csr_word_u;

endpackage

/* mmio_csr_ctrl.sv */
// MMIO register block
`timescale 1ns/1ps

module mmio_csr_ctrl
    import afu_pkg::*;
(
    input  logic                   pClk,
    input  logic                   arst_n,
    input  logic                   mmio_wr_valid,
    input  logic                   mmio_rd_valid,
    input  logic [MMIO_ADDR_W-1:0] mmio_addr,
    input  logic [DATA_W-1:0]      mmio_wdata,
    input  logic [TID_W-1:0]       mmio_tid,
    input  logic                   busy,
    input  logic                   done,
    input  logic [DATA_W-1:0]      sum,
    input  logic [CNT_W-1:0]       rsp_count,
    output logic                   mmio_rd_rsp_valid,
    output logic [TID_W-1:0]       mmio_rd_rsp_tid,
    output logic [DATA_W-1:0]      mmio_rd_rsp_data,
    output logic                   start,
    output logic [ADDR_W-1:0]      base_addr,
    output logic [CNT_W-1:0]       line_count
);

    // Write strobes, one per writable register
    logic      wr_base;
    logic      wr_count;
    logic      wr_ctrl;
    // Read word for the current address, before the output register
    csr_word_u rd_word;

    // ========================================
    // Write decode
    // ========================================

    assign wr_base  = mmio_wr_valid && (mmio_addr == CSR_BASE);
    assign wr_count = mmio_wr_valid && (mmio_addr == CSR_COUNT);
    assign wr_ctrl  = mmio_wr_valid && (mmio_addr == CSR_CTRL);

    // Base and count take the written value at the sampling edge
    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            base_addr  <= '0;
            line_count <= '0;
        end
        else
        begin
            if (wr_base)
                base_addr <= mmio_wdata[ADDR_W-1:0];
            if (wr_count)
                line_count <= mmio_wdata[CNT_W-1:0];
        end
    end

    // Bit 0 of a control write launches a run, but only from idle
    // A start still in flight counts as busy, since the engine flag lags it by a cycle
    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
            start <= 1'b0;
        else
            start <= wr_ctrl && mmio_wdata[0] && !busy && !start;
    end

    // ========================================
    // Read decode
    // ========================================

    always_comb
    begin
        // Anything not listed below reads as zero
        rd_word.raw = '0;
        case (mmio_addr)
            CSR_DFH:
            begin
                // Header of an accelerator that links on to the next feature
                rd_word.dfh.feature_type = DFH_TYPE_AFU;
                rd_word.dfh.end_of_list  = 1'b0;
                rd_word.dfh.next_offset  = NEXT_DFH_OFFSET;
            end
            CSR_ID_L:    rd_word.raw = AFU_ID_L;
            CSR_ID_H:    rd_word.raw = AFU_ID_H;
            CSR_BASE:    rd_word.raw = {{(DATA_W-ADDR_W){1'b0}}, base_addr};
            CSR_COUNT:   rd_word.raw = {{(DATA_W-CNT_W){1'b0}}, line_count};
            // Status carries busy in bit 0 and done in bit 1
            CSR_STATUS:  rd_word.raw = {{(DATA_W-2){1'b0}}, done, busy};
            CSR_SUM:     rd_word.raw = sum;
            CSR_RSP_CNT: rd_word.raw = {{(DATA_W-CNT_W){1'b0}}, rsp_count};
            default:     rd_word.raw = '0;
        endcase
    end

    // Read response leaves one cycle after the request, tag unchanged
    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mmio_rd_rsp_valid <= 1'b0;
            mmio_rd_rsp_tid   <= '0;
            mmio_rd_rsp_data  <= '0;
        end
        else
        begin
            mmio_rd_rsp_valid <= mmio_rd_valid;
            // Payload only moves when there is a read, so it holds otherwise
            if (mmio_rd_valid)
            begin
                mmio_rd_rsp_tid  <= mmio_tid;
                mmio_rd_rsp_data <= rd_word.raw;
            end
        end
    end

endmodule

/* mem_read_engine.sv */
// Line read request engine
`timescale 1ns/1ps

module mem_read_engine
    import afu_pkg::*;
(
    input  logic              pClk,
    input  logic              arst_n,
    input  logic              start,
    input  logic [ADDR_W-1:0] base_addr,
    input  logic [CNT_W-1:0]  line_count,
    input  logic              done,
    input  logic              rd_req_almost_full,
    output logic              rd_req_valid,
    output logic [ADDR_W-1:0] rd_req_addr,
    output logic              busy
);

    // Address of the next line to request
    logic [ADDR_W-1:0] next_addr;
    // Issue counter, lines still to be requested in this run
    logic [CNT_W-1:0]  lines_left;

    // ========================================
    // Request side
    // ========================================

    // A request goes out whenever lines remain and the host is not almost full
    // Almost-full is checked in the same cycle, so nothing slips past it
    assign rd_req_valid = busy && (lines_left != '0) && !rd_req_almost_full;
    assign rd_req_addr  = next_addr;

    // ========================================
    // Run state
    // ========================================

    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy       <= 1'b0;
            next_addr  <= '0;
            lines_left <= '0;
        end
        else if (start)
        begin
            // Parameters are captured here, so later CSR writes leave the run alone
            busy       <= 1'b1;
            next_addr  <= base_addr;
            lines_left <= line_count;
        end
        else
        begin
            // Under back-pressure the address simply holds until a request is sent
            if (rd_req_valid)
            begin
                next_addr  <= next_addr + 1'b1;
                lines_left <= lines_left - 1'b1;
            end
            // The run is over only once every response has been folded in
            if (done)
                busy <= 1'b0;
        end
    end

endmodule

/* rsp_accumulator.sv */
// Read response checksum collector
`timescale 1ns/1ps

module rsp_accumulator
    import afu_pkg::*;
(
    input  logic              pClk,
    input  logic              arst_n,
    input  logic              start,
    input  logic [CNT_W-1:0]  line_count,
    input  logic              rd_rsp_valid,
    input  logic [DATA_W-1:0] rd_rsp_data,
    output logic [DATA_W-1:0] sum,
    output logic [CNT_W-1:0]  rsp_count,
    output logic              done
);

    // Number of responses expected in the current run
    logic [CNT_W-1:0] target_count;
    // Response count after the response in this cycle
    logic [CNT_W-1:0] count_next;

    assign count_next = rsp_count + 1'b1;

    // ========================================
    // Checksum and completion
    // ========================================

    // The sum wraps at 64 bits, so the arrival order of responses does not matter
    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sum          <= '0;
            rsp_count    <= '0;
            done         <= 1'b0;
            target_count <= '0;
        end
        else if (start)
        begin
            // A new run wipes the previous result
            sum          <= '0;
            rsp_count    <= '0;
            done         <= 1'b0;
            target_count <= line_count;
        end
        else if (rd_rsp_valid)
        begin
            sum       <= sum + rd_rsp_data;
            rsp_count <= count_next;
            // Done goes high together with the final count and stays up
            if (count_next == target_count)
                done <= 1'b1;
        end
    end

endmodule

/* afu_top.sv */
// Memory test accelerator top level
`timescale 1ns/1ps

module afu_top
    import afu_pkg::*;
(
    input  logic                   pClk,
    input  logic                   arst_n,
    // MMIO requests, writes and reads share the address
    input  logic                   mmio_wr_valid,
    input  logic                   mmio_rd_valid,
    input  logic [MMIO_ADDR_W-1:0] mmio_addr,
    input  logic [DATA_W-1:0]      mmio_wdata,
    input  logic [TID_W-1:0]       mmio_tid,
    // MMIO read response
    output logic                   mmio_rd_rsp_valid,
    output logic [TID_W-1:0]       mmio_rd_rsp_tid,
    output logic [DATA_W-1:0]      mmio_rd_rsp_data,
    // Memory read channel
    output logic                   rd_req_valid,
    output logic [ADDR_W-1:0]      rd_req_addr,
    input  logic                   rd_req_almost_full,
    input  logic                   rd_rsp_valid,
    input  logic [DATA_W-1:0]      rd_rsp_data
);

    // Run control from the register block
    logic              start;
    logic [ADDR_W-1:0] base_addr;
    logic [CNT_W-1:0]  line_count;
    // Run state fed back into the status registers
    logic              busy;
    logic              done;
    logic [DATA_W-1:0] sum;
    logic [CNT_W-1:0]  rsp_count;

    // ========================================
    // Register block
    // ========================================

    mmio_csr_ctrl u_csr
    (
        .pClk              (pClk),
        .arst_n            (arst_n),
        .mmio_wr_valid     (mmio_wr_valid),
        .mmio_rd_valid     (mmio_rd_valid),
        .mmio_addr         (mmio_addr),
        .mmio_wdata        (mmio_wdata),
        .mmio_tid          (mmio_tid),
        .busy              (busy),
        .done              (done),
        .sum               (sum),
        .rsp_count         (rsp_count),
        .mmio_rd_rsp_valid (mmio_rd_rsp_valid),
        .mmio_rd_rsp_tid   (mmio_rd_rsp_tid),
        .mmio_rd_rsp_data  (mmio_rd_rsp_data),
        .start             (start),
        .base_addr         (base_addr),
        .line_count        (line_count)
    );

    // ========================================
    // Request and response path
    // ========================================

    // The engine stops on the collector's done, which closes the loop on the count
    mem_read_engine u_engine
    (
        .pClk               (pClk),
        .arst_n             (arst_n),
        .start              (start),
        .base_addr          (base_addr),
        .line_count         (line_count),
        .done               (done),
        .rd_req_almost_full (rd_req_almost_full),
        .rd_req_valid       (rd_req_valid),
        .rd_req_addr        (rd_req_addr),
        .busy               (busy)
    );

    rsp_accumulator u_accum
    (
        .pClk         (pClk),
        .arst_n       (arst_n),
        .start        (start),
        .line_count   (line_count),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_data  (rd_rsp_data),
        .sum          (sum),
        .rsp_count    (rsp_count),
        .done         (done)
    );

endmodule

/* afu_assertions.sv */
// Host bus protocol assertions
`timescale 1ns/1ps

module afu_assertions
(
    input logic pClk,
    input logic arst_n,
    input logic mmio_rd_valid,
    input logic mmio_rd_rsp_valid,
    input logic rd_req_valid,
    input logic rd_req_almost_full
);

    // Failures seen so far, summed into the closing count
    int fail_count = 0;

    // Almost-full is the only back-pressure, so a request under it would be lost
    no_req_when_full: assert property (@(posedge pClk) disable iff (!arst_n)
        rd_req_almost_full |-> !rd_req_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("read request issued while almost-full was high");
    end

    // Every MMIO read is answered exactly one cycle later
    mmio_rsp_follows_read: assert property (@(posedge pClk) disable iff (!arst_n)
        mmio_rd_valid |=> mmio_rd_rsp_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("MMIO read not answered one cycle later");
    end

    quiet_in_reset: assert property (@(posedge pClk)
        !arst_n |-> !mmio_rd_rsp_valid && !rd_req_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("valid output raised during reset");
    end

endmodule

bind afu_top afu_assertions u_assert
(
    .pClk               (pClk),
    .arst_n             (arst_n),
    .mmio_rd_valid      (mmio_rd_valid),
    .mmio_rd_rsp_valid  (mmio_rd_rsp_valid),
    .rd_req_valid       (rd_req_valid),
    .rd_req_almost_full (rd_req_almost_full)
);

/* afu_checker.sv */
// Accelerator reference model and checks
`timescale 1ns/1ps

module afu_checker
    import afu_pkg::*;
(
    input logic                   pClk,
    input logic                   arst_n,
    input logic                   mmio_wr_valid,
    input logic                   mmio_rd_valid,
    input logic [MMIO_ADDR_W-1:0] mmio_addr,
    input logic [DATA_W-1:0]      mmio_wdata,
    input logic [TID_W-1:0]       mmio_tid,
    input logic                   mmio_rd_rsp_valid,
    input logic [TID_W-1:0]       mmio_rd_rsp_tid,
    input logic [DATA_W-1:0]      mmio_rd_rsp_data,
    input logic                   rd_req_valid,
    input logic [ADDR_W-1:0]      rd_req_addr,
    input logic                   rd_rsp_valid
);

    // Running totals that the testbench top reads for the summary
    int error_count  = 0;
    int test_count   = 0;
    int failed_tests = 0;
    int errors_seen  = 0;

    // Register mirror as written over MMIO
    logic [ADDR_W-1:0] base_m;
    logic [CNT_W-1:0]  count_m;
    // Run model with the captured parameters, progress and expected checksum
    logic              run_active;
    logic              run_done;
    logic [ADDR_W-1:0] run_base;
    logic [CNT_W-1:0]  run_count;
    logic [CNT_W-1:0]  issued;
    logic [CNT_W-1:0]  returned;
    logic [DATA_W-1:0] exp_sum;
    logic [63:0]       seen;
    // Busy as the status word shows it, one cycle behind the run model
    logic              busy_m;
    // Read in flight whose response is due at the next edge
    logic              rd_pend;
    logic [TID_W-1:0]  exp_tid;
    logic [DATA_W-1:0] exp_data;
    logic [DATA_W-1:0] exp_mask;

    // Host memory content is a hash over every address bit
    function automatic logic [DATA_W-1:0] mix_data(input logic [ADDR_W-1:0] addr);
        logic [63:0] x;
        x = {22'h0, addr} * 64'h9e37_79b9_7f4a_7c15;
        return x ^ (x >> 29) ^ 64'h5bd1_e995_0000_0000;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s got 0x%h expected 0x%h", sig, got, exp);
        error_count = error_count + 1;
    endtask

    task automatic report_fault(input string what);
        $display("Check failed: %s", what);
        error_count = error_count + 1;
    endtask

    // ========================================
    // Expected read data
    // ========================================

    // Mask bits at zero are not compared while run results are unsettled
    function automatic void expect_read(input logic [MMIO_ADDR_W-1:0] addr,
                                        output logic [DATA_W-1:0] data,
                                        output logic [DATA_W-1:0] mask);
        csr_word_u w;
        w.raw = '0;
        mask  = '1;
        case (addr)
            CSR_DFH:
            begin
                w.dfh.feature_type = DFH_TYPE_AFU;
                w.dfh.next_offset  = NEXT_DFH_OFFSET;
            end
            CSR_ID_L:  w.raw = AFU_ID_L;
            CSR_ID_H:  w.raw = AFU_ID_H;
            CSR_BASE:  w.raw = DATA_W'(base_m);
            CSR_COUNT: w.raw = DATA_W'(count_m);
            // Done rises with the last response while busy trails the run by a cycle
            CSR_STATUS: w.raw = DATA_W'({run_done, busy_m});
            CSR_SUM:
            begin
                w.raw = exp_sum;
                mask  = run_done ? '1 : '0;
            end
            CSR_RSP_CNT:
            begin
                w.raw = DATA_W'(run_count);
                mask  = run_done ? '1 : '0;
            end
            default:   w.raw = '0;
        endcase
        data = w.raw;
    endfunction

    // ========================================
    // Model and comparison
    // ========================================

    always @(posedge pClk or negedge arst_n)
    begin : model
        logic [DATA_W-1:0] e_data;
        logic [DATA_W-1:0] e_mask;
        logic [DATA_W-1:0] acc;
        logic [ADDR_W-1:0] offset;
        if (!arst_n)
        begin
            base_m     <= '0;
            count_m    <= '0;
            run_active <= 1'b0;
            run_done   <= 1'b0;
            run_base   <= '0;
            run_count  <= '0;
            issued     <= '0;
            returned   <= '0;
            exp_sum    <= '0;
            seen       <= '0;
            busy_m     <= 1'b0;
            rd_pend    <= 1'b0;
            exp_tid    <= '0;
            exp_data   <= '0;
            exp_mask   <= '0;
        end
        else
        begin
            // The response belongs to the read of the previous cycle
            if (rd_pend && !mmio_rd_rsp_valid)
                report_fault("MMIO read got no response one cycle later");
            else if (rd_pend)
            begin
                if (mmio_rd_rsp_tid !== exp_tid)
                    report_mismatch("mmio_rd_rsp_tid", 64'(mmio_rd_rsp_tid), 64'(exp_tid));
                if ((mmio_rd_rsp_data & exp_mask) !== (exp_data & exp_mask))
                    report_mismatch("mmio_rd_rsp_data", mmio_rd_rsp_data, exp_data);
            end
            else if (mmio_rd_rsp_valid)
                report_fault("MMIO response without a read");
            rd_pend <= mmio_rd_valid;
            if (mmio_rd_valid)
            begin
                expect_read(mmio_addr, e_data, e_mask);
                exp_tid  <= mmio_tid;
                exp_data <= e_data;
                exp_mask <= e_mask;
            end

            // Busy follows the start by a cycle and drops a cycle after done
            busy_m <= run_active;

            if (mmio_wr_valid && mmio_addr == CSR_BASE)
                base_m <= mmio_wdata[ADDR_W-1:0];
            if (mmio_wr_valid && mmio_addr == CSR_COUNT)
                count_m <= mmio_wdata[CNT_W-1:0];
            // A start is honoured only from idle, and it captures the parameters
            if (mmio_wr_valid && mmio_addr == CSR_CTRL && mmio_wdata[0] && !run_active)
            begin
                acc = '0;
                for (int i = 0; i < count_m; i++)
                    acc = acc + mix_data(base_m + ADDR_W'(i));
                run_active <= 1'b1;
                run_done   <= 1'b0;
                run_base   <= base_m;
                run_count  <= count_m;
                issued     <= '0;
                returned   <= '0;
                seen       <= '0;
                exp_sum    <= acc;
            end

            // Each line of the run is requested once and nothing outside it
            if (rd_req_valid)
            begin
                offset = rd_req_addr - run_base;
                if (!run_active)
                    report_fault("read request while no run is active");
                else if (offset >= ADDR_W'(run_count) || offset > 63)
                    report_fault($sformatf("request address 0x%h outside the run", rd_req_addr));
                else if (seen[offset[5:0]])
                    report_fault($sformatf("request address 0x%h issued twice", rd_req_addr));
                else
                begin
                    seen[offset[5:0]] <= 1'b1;
                    issued            <= issued + 1'b1;
                end
            end

            if (rd_rsp_valid && !run_active)
                report_fault("read response while no run is active");
            else if (rd_rsp_valid)
            begin
                returned <= returned + 1'b1;
                if (CNT_W'(returned + 1'b1) == run_count)
                begin
                    run_active <= 1'b0;
                    run_done   <= 1'b1;
                end
            end
        end
    end

    // Called once the DUT reported done and its results were read
    task automatic check_run();
        if (!run_done)
            report_fault("DUT reported done before every response arrived");
        if (issued !== run_count)
            report_mismatch("rd_req_valid count", 64'(issued), 64'(run_count));
    endtask

    task automatic finish_test(input string name);
        test_count = test_count + 1;
        if (error_count != errors_seen)
        begin
            failed_tests = failed_tests + 1;
            $display("test %-12s FAIL with %0d errors", name, error_count - errors_seen);
        end
        else
            $display("test %-12s ok", name);
        errors_seen = error_count;
    endtask

endmodule

/* tb_top.sv */
// Memory test accelerator testbench
`timescale 1ns/1ps

module tb_top
    import afu_pkg::*;
();

    logic                   pClk;
    logic                   arst_n;
    logic                   mmio_wr_valid;
    logic                   mmio_rd_valid;
    logic [MMIO_ADDR_W-1:0] mmio_addr;
    logic [DATA_W-1:0]      mmio_wdata;
    logic [TID_W-1:0]       mmio_tid;
    logic                   mmio_rd_rsp_valid;
    logic [TID_W-1:0]       mmio_rd_rsp_tid;
    logic [DATA_W-1:0]      mmio_rd_rsp_data;
    logic                   rd_req_valid;
    logic [ADDR_W-1:0]      rd_req_addr;
    logic                   rd_req_almost_full;
    logic                   rd_rsp_valid;
    logic [DATA_W-1:0]      rd_rsp_data;

    // Set by any wait that runs out, later tests are then skipped
    bit                     timed_out;
    int                     total_errors;
    // Line addresses requested and not yet answered
    logic [ADDR_W-1:0]      pending_q[$];

    afu_top dut_i
    (
        .pClk               (pClk),
        .arst_n             (arst_n),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_addr          (mmio_addr),
        .mmio_wdata         (mmio_wdata),
        .mmio_tid           (mmio_tid),
        .mmio_rd_rsp_valid  (mmio_rd_rsp_valid),
        .mmio_rd_rsp_tid    (mmio_rd_rsp_tid),
        .mmio_rd_rsp_data   (mmio_rd_rsp_data),
        .rd_req_valid       (rd_req_valid),
        .rd_req_addr        (rd_req_addr),
        .rd_req_almost_full (rd_req_almost_full),
        .rd_rsp_valid       (rd_rsp_valid),
        .rd_rsp_data        (rd_rsp_data)
    );

    afu_checker chk_i
    (
        .pClk              (pClk),
        .arst_n            (arst_n),
        .mmio_wr_valid     (mmio_wr_valid),
        .mmio_rd_valid     (mmio_rd_valid),
        .mmio_addr         (mmio_addr),
        .mmio_wdata        (mmio_wdata),
        .mmio_tid          (mmio_tid),
        .mmio_rd_rsp_valid (mmio_rd_rsp_valid),
        .mmio_rd_rsp_tid   (mmio_rd_rsp_tid),
        .mmio_rd_rsp_data  (mmio_rd_rsp_data),
        .rd_req_valid      (rd_req_valid),
        .rd_req_addr       (rd_req_addr),
        .rd_rsp_valid      (rd_rsp_valid)
    );

    always #20 pClk = ~pClk;

    // ========================================
    // Host memory model
    // ========================================

    always @(posedge pClk)
    begin
        if (arst_n && rd_req_valid)
            pending_q.push_back(rd_req_addr);
    end

    // Answers one pending line at random with random gaps, so order is scrambled
    always @(negedge pClk)
    begin : host_memory
        int                pick;
        logic [ADDR_W-1:0] addr;
        rd_rsp_valid       = 1'b0;
        rd_req_almost_full = ($urandom % 4) == 0;
        if (arst_n && pending_q.size() != 0 && ($urandom % 3) != 0)
        begin
            pick = $urandom % pending_q.size();
            addr = pending_q[pick];
            pending_q.delete(pick);
            rd_rsp_valid = 1'b1;
            rd_rsp_data  = chk_i.mix_data(addr);
        end
    end

    // ========================================
    // MMIO access tasks
    // ========================================

    task automatic mmio_write(input logic [MMIO_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge pClk);
        mmio_wr_valid = 1'b1;
        mmio_addr     = addr;
        mmio_wdata    = data;
        @(negedge pClk);
        mmio_wr_valid = 1'b0;
    endtask

    task automatic mmio_read(input logic [MMIO_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int waited;
        data   = '0;
        waited = 0;
        if (timed_out)
            return;
        @(negedge pClk);
        mmio_rd_valid = 1'b1;
        mmio_addr     = addr;
        mmio_tid      = TID_W'($urandom);
        @(negedge pClk);
        mmio_rd_valid = 1'b0;
        while (!mmio_rd_rsp_valid && waited < 16)
        begin
            @(negedge pClk);
            waited++;
        end
        if (mmio_rd_rsp_valid)
            data = mmio_rd_rsp_data;
        else
        begin
            timed_out = 1'b1;
            $display("Timeout: no MMIO read response for address 0x%h", addr);
        end
    endtask

    // Polls the status word until the done bit shows
    task automatic wait_done();
        logic [DATA_W-1:0] status;
        int                polls;
        status = '0;
        polls  = 0;
        while (!status[1] && !timed_out && polls < 400)
        begin
            mmio_read(CSR_STATUS, status);
            polls++;
        end
        if (!status[1] && !timed_out)
        begin
            timed_out = 1'b1;
            $display("Timeout: the run never reported done");
        end
    endtask

    // ========================================
    // Tests
    // ========================================

    task automatic test_ids();
        logic [DATA_W-1:0] rdata;
        mmio_read(CSR_DFH, rdata);
        mmio_read(CSR_ID_L, rdata);
        mmio_read(CSR_ID_H, rdata);
        chk_i.finish_test("dfh_ids");
    endtask

    task automatic test_csr_rw();
        logic [DATA_W-1:0] rdata;
        for (int i = 0; i < 8; i++)
        begin
            mmio_write(CSR_BASE, {$urandom, $urandom});
            mmio_write(CSR_COUNT, {$urandom, $urandom});
            mmio_read(CSR_BASE, rdata);
            mmio_read(CSR_COUNT, rdata);
            // Everything from 0x50 upward is outside the map
            mmio_read(MMIO_ADDR_W'(16'h0050 + ($urandom % 16'hffb0)), rdata);
        end
        mmio_read(16'h0018, rdata);
        chk_i.finish_test("csr_rw");
    endtask

    // One run over random lines, with an optional second start while busy
    task automatic run_lines(input string name, input bit restart);
        logic [ADDR_W-1:0] base;
        logic [CNT_W-1:0]  count;
        logic [DATA_W-1:0] rdata;
        base  = ADDR_W'({$urandom, $urandom});
        count = restart ? CNT_W'(16 + $urandom % 49) : CNT_W'(1 + $urandom % 64);
        if (timed_out)
            return;
        mmio_write(CSR_BASE, DATA_W'(base));
        mmio_write(CSR_COUNT, DATA_W'(count));
        mmio_write(CSR_CTRL, 64'h1);
        if (restart)
        begin
            // The run already holds its parameters, so neither write may disturb it
            mmio_write(CSR_CTRL, 64'h1);
            mmio_write(CSR_BASE, {$urandom, $urandom});
        end
        wait_done();
        mmio_read(CSR_SUM, rdata);
        mmio_read(CSR_RSP_CNT, rdata);
        if (!timed_out)
            chk_i.check_run();
        chk_i.finish_test(name);
    endtask

    initial
    begin
        void'($urandom(32'hfe656434));
        pClk               = 1'b0;
        arst_n             = 1'b0;
        mmio_wr_valid      = 1'b0;
        mmio_rd_valid      = 1'b0;
        mmio_addr          = '0;
        mmio_wdata         = '0;
        mmio_tid           = '0;
        rd_req_almost_full = 1'b0;
        rd_rsp_valid       = 1'b0;
        rd_rsp_data        = '0;
        timed_out          = 1'b0;
        repeat (3) @(posedge pClk);
        @(negedge pClk);
        arst_n = 1'b1;

        test_ids();
        test_csr_rw();
        run_lines("run_a", 1'b0);
        run_lines("run_b", 1'b0);
        run_lines("busy_start", 1'b1);
        run_lines("second_run", 1'b0);

        total_errors = chk_i.error_count + dut_i.u_assert.fail_count;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 chk_i.test_count, chk_i.failed_tests, total_errors,
                 dut_i.u_assert.fail_count);
        if (timed_out || total_errors != 0)
            $display("SIMULATION FAILED");
        else
            $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* build.f */
afu_pkg.sv
mmio_csr_ctrl.sv
mem_read_engine.sv
rsp_accumulator.sv
afu_top.sv
afu_assertions.sv
afu_checker.sv
tb_top.sv
